//--- verilog/memStagePkg.sv
// shared types and constants of the memory stage, imported by every stage module
package memStagePkg;

    typedef logic [31:0] wordT;    // data or address word
    typedef logic [4:0]  regAddrT; // gpr or cp0 register number
    typedef logic [18:0] vpn2T;    // vaddr[31:13]
    typedef logic [19:0] pfnT;
    typedef logic [3:0]  byteEnT;

    // mips cause codes
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excTlbL = 5'd2,
        excTlbS = 5'd3,
        excAdEL = 5'd4,
        excAdES = 5'd5,
        excSys  = 5'd8,
        excBp   = 5'd9,
        excRI   = 5'd10,
        excOv   = 5'd12
    } excCodeE;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeE;

    typedef enum logic [1:0] {
        wbPcPlus8 = 2'd0, // jump and link
        wbAluOut  = 2'd1,
        wbCp0Data = 2'd2  // mfc0
    } wbSelE;

    // exceptions flagged by earlier stages
    typedef struct packed {
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic overflow;
        logic eret;
    } upExcT;

    typedef struct packed {
        logic    valid;
        wordT    pc;
        wordT    instr;
        wordT    aluOut;    // also the data address
        wordT    storeData; // rt value, also mtc0 data
        regAddrT dst;
        logic    regWrite;
        wbSelE   wbSel;
        logic    isLoad;
        logic    isStore;
        memSizeE memSize;
        byteEnT  byteEn;
        logic    isMtc0;
        logic    isMfc0;
        regAddrT cp0Addr;
        logic    inDelaySlot;
        upExcT   upExc;
    } exeToMemT;

    // even/odd page pair as returned by the external tlb
    typedef struct packed {
        vpn2T vpn2;
        pfnT  pfn0;
        logic v0;
        logic c0;
        pfnT  pfn1;
        logic v1;
        logic c1;
    } tlbEntryT;

    typedef struct packed {
        logic   valid;
        logic   write;
        wordT   paddr;
        byteEnT byteEn;
        wordT   wdata;
        logic   cached;
    } dmemReqT;

    typedef struct packed {
        logic    regWrite;
        regAddrT dst;
        wordT    result;
    } memToWbT;

    localparam regAddrT cp0BadVAddr = 5'd8;
    localparam regAddrT cp0EntryHi  = 5'd10;
    localparam regAddrT cp0Status   = 5'd12;
    localparam regAddrT cp0Cause    = 5'd13;
    localparam regAddrT cp0Epc      = 5'd14;

    localparam wordT refillOffset  = 32'h0000_0000;
    localparam wordT generalOffset = 32'h0000_0180;
    localparam wordT bevBase       = 32'hBFC0_0200;
    localparam wordT normalBase    = 32'h8000_0000;

endpackage

//--- verilog/memReg.sv
// execute-to-memory pipeline register, loaded by memWr and invalidated by memFlush
module memReg (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  memWr,
    input  logic                  memFlush,
    input  memStagePkg::exeToMemT exeIn,
    output memStagePkg::exeToMemT memIn
);
    import memStagePkg::*;

    logic     validQ;
    exeToMemT payloadQ;

    // valid is the only control bit of the stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else if (memFlush) begin
            validQ <= 1'b0; // flush beats write
        end else if (memWr) begin
            validQ <= exeIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (memWr) begin
            payloadQ <= exeIn;
        end
    end

    always_comb begin
        memIn       = payloadQ;
        memIn.valid = validQ;
    end

    // known strobes keep the held instruction's valid bit known
    assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown({memWr, memFlush}) |=> !$isunknown(validQ));

endmodule

//--- verilog/dataTlbBuffer.sv
// data address translation with kseg0/kseg1 decode and a one-entry buffer refilled from the TLB
module dataTlbBuffer (
    input  logic                  clk,
    input  logic                  arstN,
    input  memStagePkg::wordT     vaddr,
    input  logic                  access,   // valid load or store
    input  logic                  bufFlush, // mtc0 to EntryHi
    input  memStagePkg::tlbEntryT tlbEntry,
    input  logic                  tlbFound,
    output memStagePkg::wordT     paddr,
    output logic                  cached,
    output memStagePkg::vpn2T     tlbVpn2,
    output logic                  tlbStall,
    output logic                  tlbRefill
);
    import memStagePkg::*;

    tlbEntryT entryQ;
    logic     entryValidQ;
    logic     unmapped;
    logic     vpnHit;
    logic     oddPage;
    logic     pageValid;
    logic     pageCached;
    pfnT      pagePfn;

    assign unmapped = (vaddr[31:30] == 2'b10);  // kseg0 or kseg1
    assign vpnHit   = entryValidQ && (entryQ.vpn2 == vaddr[31:13]);
    assign oddPage  = vaddr[12];

    // pick the half of the page pair
    assign pagePfn    = oddPage ? entryQ.pfn1 : entryQ.pfn0;
    assign pageValid  = oddPage ? entryQ.v1   : entryQ.v0;
    assign pageCached = oddPage ? entryQ.c1   : entryQ.c0;

    always_comb begin
        if (unmapped) begin
            paddr  = {3'b000, vaddr[28:0]};
            cached = !vaddr[29]; // kseg1 is uncached
        end else begin
            paddr  = {pagePfn, vaddr[11:0]};
            cached = pageCached;
        end
    end

    assign tlbVpn2 = vaddr[31:13];

    // miss with an answer stalls one cycle, otherwise it is a refill exception
    assign tlbStall  = access && !unmapped && !vpnHit && tlbFound;
    assign tlbRefill = access && !unmapped && (vpnHit ? !pageValid : !tlbFound);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValidQ <= 1'b0;
        end else if (bufFlush) begin
            entryValidQ <= 1'b0;
        end else if (tlbStall) begin
            entryValidQ <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbStall) begin
            entryQ <= tlbEntry;
        end
    end

    // a refill never coincides with a stall, and the held access hits after it
    assert property (@(posedge clk) disable iff (!arstN)
        tlbStall |-> !tlbRefill ##1 !tlbStall);

endmodule

//--- verilog/cp0Regs.sv
// coprocessor-0 state: Status, Cause, EPC, BadVAddr and EntryHi with mtc0/mfc0, commit and eret
module cp0Regs (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [5:0]            interrupt,
    input  memStagePkg::exeToMemT memIn,
    input  logic                  excTaken,
    input  memStagePkg::excCodeE  excCode,
    input  logic                  isEret,
    input  logic                  setBadVAddr,
    output memStagePkg::wordT     rdData,
    output logic                  statusBev,
    output logic                  statusExl,
    output logic                  intPending,
    output memStagePkg::wordT     epc,
    output logic                  entryHiWrite
);
    import memStagePkg::*;

    logic       statusIe;
    logic [7:0] statusIm;
    logic       causeBd;
    logic [5:0] causeIpHw; // ip7..2
    logic [1:0] causeIpSw; // ip1..0, software
    excCodeE    causeExc;
    wordT       badVAddrQ;
    vpn2T       entryHiVpn2;
    logic [7:0] entryHiAsid;
    logic       mtc0Wr;
    wordT       wrData;

    assign mtc0Wr       = memIn.valid && memIn.isMtc0 && !excTaken;
    assign wrData       = memIn.storeData;
    assign entryHiWrite = mtc0Wr && (memIn.cp0Addr == cp0EntryHi);

    assign intPending = statusIe && !statusExl && |({causeIpHw, causeIpSw} & statusIm);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusBev   <= 1'b1;
            statusIm    <= '0;
            statusExl   <= 1'b0;
            statusIe    <= 1'b0;
            causeBd     <= 1'b0;
            causeIpHw   <= '0;
            causeIpSw   <= '0;
            causeExc    <= excInt;
            epc         <= '0;
            badVAddrQ   <= '0;
            entryHiVpn2 <= '0;
            entryHiAsid <= '0;
        end else begin
            causeIpHw <= interrupt; // sampled every cycle
            if (excTaken) begin
                epc       <= memIn.inDelaySlot ? memIn.pc - 32'd4 : memIn.pc;
                causeBd   <= memIn.inDelaySlot;
                causeExc  <= excCode;
                statusExl <= 1'b1;
                if (setBadVAddr) begin
                    badVAddrQ <= memIn.aluOut;
                end
                if (excCode == excTlbL || excCode == excTlbS) begin
                    entryHiVpn2 <= memIn.aluOut[31:13];
                end
            end else if (isEret) begin
                statusExl <= 1'b0;
            end else if (mtc0Wr) begin
                case (memIn.cp0Addr)
                    cp0Status: begin
                        statusBev <= wrData[22];
                        statusIm  <= wrData[15:8];
                        statusExl <= wrData[1];
                        statusIe  <= wrData[0];
                    end
                    cp0Cause: causeIpSw <= wrData[9:8]; // only soft ip is writable
                    cp0Epc:   epc <= wrData;
                    cp0EntryHi: begin
                        entryHiVpn2 <= wrData[31:13];
                        entryHiAsid <= wrData[7:0];
                    end
                    default: ; // BadVAddr and others are read only
                endcase
            end
        end
    end

    // mfc0 read
    always_comb begin
        case (memIn.cp0Addr)
            cp0BadVAddr: rdData = badVAddrQ;
            cp0EntryHi:  rdData = {entryHiVpn2, 5'b0, entryHiAsid};
            cp0Status:   rdData = {9'b0, statusBev, 6'b0, statusIm, 6'b0, statusExl, statusIe};
            cp0Cause:    rdData = {causeBd, 15'b0, causeIpHw, causeIpSw, 1'b0, causeExc, 2'b0};
            cp0Epc:      rdData = epc;
            default:     rdData = '0;
        endcase
    end

endmodule

//--- verilog/exceptionUnit.sv
// ranks the exception causes of the memory-stage instruction and selects the flush vector
module exceptionUnit (
    input  memStagePkg::exeToMemT memIn,
    input  logic                  tlbRefill,
    input  logic                  tlbStall,
    input  logic                  intPending,
    input  logic                  statusBev,
    input  logic                  statusExl,
    input  memStagePkg::wordT     epc,
    output logic                  excFlush,
    output logic                  excTaken,
    output memStagePkg::excCodeE  excCode,
    output logic                  isEret,
    output logic                  setBadVAddr,
    output memStagePkg::wordT     excVector
);
    import memStagePkg::*;

    logic live;
    logic misaligned;
    logic refillCause;
    wordT base;

    assign live = memIn.valid && !tlbStall; // stalled instruction raises nothing yet

    always_comb begin
        case (memIn.memSize)
            sizeHalf: misaligned = memIn.aluOut[0];
            sizeWord: misaligned = |memIn.aluOut[1:0];
            default:  misaligned = 1'b0;
        endcase
    end

    // highest priority first
    always_comb begin
        excTaken    = live;
        excCode     = excInt;
        isEret      = 1'b0;
        setBadVAddr = 1'b0;
        if (!live) begin
            excTaken = 1'b0;
        end else if (intPending) begin
            excCode = excInt;
        end else if ((memIn.isLoad || memIn.isStore) && misaligned) begin
            excCode     = memIn.isStore ? excAdES : excAdEL;
            setBadVAddr = 1'b1;
        end else if (tlbRefill) begin
            excCode     = memIn.isStore ? excTlbS : excTlbL;
            setBadVAddr = 1'b1;
        end else if (memIn.upExc.reservedInstr) begin
            excCode = excRI;
        end else if (memIn.upExc.syscall) begin
            excCode = excSys;
        end else if (memIn.upExc.brk) begin
            excCode = excBp;
        end else if (memIn.upExc.overflow) begin
            excCode = excOv;
        end else begin
            excTaken = 1'b0;
            isEret   = memIn.upExc.eret;
        end
    end

    assign excFlush    = excTaken || isEret;
    assign refillCause = excTaken && (excCode == excTlbL || excCode == excTlbS);
    assign base        = statusBev ? bevBase : normalBase;

    always_comb begin
        if (isEret) begin
            excVector = epc;
        end else if (refillCause && !statusExl) begin
            excVector = base + refillOffset;
        end else begin
            excVector = base + generalOffset;
        end
    end

endmodule

//--- verilog/memStageTop.sv
// top level of the memory stage that wires its submodules and builds the result and request
module memStageTop (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  memWr,
    input  logic                  memFlush,
    input  memStagePkg::exeToMemT exeIn,
    input  logic [5:0]            interrupt,
    input  memStagePkg::tlbEntryT tlbEntry,
    input  logic                  tlbFound,
    output memStagePkg::memToWbT  wbOut,
    output memStagePkg::dmemReqT  dmemReq,
    output memStagePkg::vpn2T     tlbVpn2,
    output logic                  tlbStall,
    output logic                  excFlush,
    output memStagePkg::wordT     excVector
);
    import memStagePkg::*;

    exeToMemT memIn;
    wordT     paddr;
    logic     cached;
    logic     access;
    logic     tlbRefill;
    logic     excTaken;
    excCodeE  excCode;
    logic     isEret;
    logic     setBadVAddr;
    wordT     cp0RdData;
    logic     statusBev;
    logic     statusExl;
    logic     intPending;
    wordT     epc;
    logic     entryHiWrite;

    assign access = memIn.valid && (memIn.isLoad || memIn.isStore);

    memReg uMemReg (
        .clk(clk), .arstN(arstN), .memWr(memWr), .memFlush(memFlush),
        .exeIn(exeIn), .memIn(memIn)
    );

    dataTlbBuffer uDataTlb (
        .clk(clk), .arstN(arstN), .vaddr(memIn.aluOut), .access(access),
        .bufFlush(entryHiWrite), .tlbEntry(tlbEntry), .tlbFound(tlbFound),
        .paddr(paddr), .cached(cached), .tlbVpn2(tlbVpn2),
        .tlbStall(tlbStall), .tlbRefill(tlbRefill)
    );

    exceptionUnit uException (
        .memIn(memIn), .tlbRefill(tlbRefill), .tlbStall(tlbStall),
        .intPending(intPending), .statusBev(statusBev), .statusExl(statusExl), .epc(epc),
        .excFlush(excFlush), .excTaken(excTaken), .excCode(excCode), .isEret(isEret),
        .setBadVAddr(setBadVAddr), .excVector(excVector)
    );

    cp0Regs uCp0 (
        .clk(clk), .arstN(arstN), .interrupt(interrupt), .memIn(memIn),
        .excTaken(excTaken), .excCode(excCode), .isEret(isEret), .setBadVAddr(setBadVAddr),
        .rdData(cp0RdData), .statusBev(statusBev), .statusExl(statusExl),
        .intPending(intPending), .epc(epc), .entryHiWrite(entryHiWrite)
    );

    // forwarding and write-back value
    always_comb begin
        case (memIn.wbSel)
            wbPcPlus8: wbOut.result = memIn.pc + 32'd8;
            wbCp0Data: wbOut.result = cp0RdData;
            default:   wbOut.result = memIn.aluOut;
        endcase
        wbOut.dst      = memIn.dst;
        wbOut.regWrite = memIn.valid && memIn.regWrite && !excFlush && !tlbStall;
    end

    always_comb begin
        dmemReq.valid  = access && !excFlush && !tlbStall;
        dmemReq.write  = memIn.isStore;
        dmemReq.paddr  = paddr;
        dmemReq.byteEn = memIn.byteEn;
        dmemReq.wdata  = memIn.storeData;
        dmemReq.cached = cached;
    end

    // the environment holds its stage write back while the buffer refills
    assert property (@(posedge clk) disable iff (!arstN) tlbStall |-> !memWr);

endmodule

//--- verif/memStageTb.sv
// testbench for the memory stage that checks directed and random instructions against a model
module memStageTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memStagePkg::*;

    // expected response of one held instruction
    typedef struct packed {
        logic    regWrite;
        regAddrT dst;
        wordT    result;
        logic    reqValid;
        logic    reqWrite;
        wordT    paddr;
        byteEnT  byteEn;
        wordT    wdata;
        logic    cached;
        logic    stall;
        logic    lookup;
        vpn2T    vpn2;
        logic    flush;
        wordT    vector;
        logic    excTaken;
        excCodeE code;
        logic    eret;
        logic    badV;
    } expT;

    localparam int maxCycles = 4000; // ~300 instructions, up to 3 cycles each, plus margin

    logic       clk;
    logic       arstN;
    logic       memWr;
    logic       memFlush;
    exeToMemT   exeIn;
    logic [5:0] interrupt;
    tlbEntryT   tlbEntry;
    logic       tlbFound;
    memToWbT    wbOut;
    dmemReqT    dmemReq;
    vpn2T       tlbVpn2;
    logic       tlbStall;
    logic       excFlush;
    wordT       excVector;

    integer   seed;
    int       errors;
    int       cycles;
    wordT     pcNext;
    tlbEntryT tlbTable [4];
    exeToMemT heldIns;   // mirror of the stage register
    logic     heldValid;
    logic [5:0] ipHwRef;
    expT      exp;

    // reference CP0 and buffer state
    logic       mBev, mExl, mIe, mBd, mBufValid;
    logic [7:0] mIm, mAsid;
    logic [1:0] mIpSw;
    excCodeE    mCode;
    wordT       mEpc, mBadV;
    vpn2T       mVpn2;
    tlbEntryT   mBuf;

    memStageTop i_dut (
        .clk(clk), .arstN(arstN), .memWr(memWr), .memFlush(memFlush), .exeIn(exeIn),
        .interrupt(interrupt), .tlbEntry(tlbEntry), .tlbFound(tlbFound), .wbOut(wbOut),
        .dmemReq(dmemReq), .tlbVpn2(tlbVpn2), .tlbStall(tlbStall), .excFlush(excFlush),
        .excVector(excVector)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // external TLB answering in the same cycle
    always_comb begin
        tlbFound = 1'b0;
        tlbEntry = '0;
        for (int i = 0; i < 4; i++) begin
            if (tlbTable[i].vpn2 == tlbVpn2) begin
                tlbFound = 1'b1;
                tlbEntry = tlbTable[i];
            end
        end
    end

    function automatic logic tlbHas(input vpn2T v);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) if (tlbTable[i].vpn2 == v) hit = 1'b1;
        return hit;
    endfunction

    function automatic tlbEntryT tlbGet(input vpn2T v);
        tlbEntryT e;
        e = '0;
        for (int i = 0; i < 4; i++) if (tlbTable[i].vpn2 == v) e = tlbTable[i];
        return e;
    endfunction

    function automatic wordT cp0Read(input regAddrT a);
        case (a)
            cp0BadVAddr: return mBadV;
            cp0EntryHi:  return {mVpn2, 5'b0, mAsid};
            cp0Status:   return {9'b0, mBev, 6'b0, mIm, 6'b0, mExl, mIe};
            cp0Cause:    return {mBd, 15'b0, ipHwRef, mIpSw, 1'b0, mCode, 2'b0};
            cp0Epc:      return mEpc;
            default:     return '0;
        endcase
    endfunction

    function automatic expT refModel(input exeToMemT ins, input logic vld);
        expT  r;
        logic access, unmapped, hit, half, pageOk, refill, live, mis, intPend;
        wordT base;
        r        = '0;
        access   = vld && (ins.isLoad || ins.isStore);
        unmapped = ins.aluOut[31:30] == 2'b10;
        hit      = mBufValid && (mBuf.vpn2 == ins.aluOut[31:13]);
        half     = ins.aluOut[12];
        pageOk   = half ? mBuf.v1 : mBuf.v0;
        r.stall  = access && !unmapped && !hit && tlbHas(ins.aluOut[31:13]);
        r.lookup = access && !unmapped && !hit;
        r.vpn2   = ins.aluOut[31:13];
        refill   = access && !unmapped && (hit ? !pageOk : !tlbHas(ins.aluOut[31:13]));
        if (unmapped) begin
            r.paddr  = {3'b000, ins.aluOut[28:0]};
            r.cached = ins.aluOut[29] == 1'b0; // kseg0
        end else begin
            r.paddr  = {half ? mBuf.pfn1 : mBuf.pfn0, ins.aluOut[11:0]};
            r.cached = half ? mBuf.c1 : mBuf.c0;
        end
        live    = vld && !r.stall;
        mis     = (ins.memSize == sizeHalf && ins.aluOut[0]) ||
                  (ins.memSize == sizeWord && |ins.aluOut[1:0]);
        intPend = mIe && !mExl && |({ipHwRef, mIpSw} & mIm);
        r.excTaken = live;
        r.code     = excInt;
        if (!live) r.excTaken = 1'b0;
        else if (intPend) r.code = excInt;
        else if ((ins.isLoad || ins.isStore) && mis) begin
            r.code = ins.isStore ? excAdES : excAdEL;
            r.badV = 1'b1;
        end else if (refill) begin
            r.code = ins.isStore ? excTlbS : excTlbL;
            r.badV = 1'b1;
        end else if (ins.upExc.reservedInstr) r.code = excRI;
        else if (ins.upExc.syscall) r.code = excSys;
        else if (ins.upExc.brk) r.code = excBp;
        else if (ins.upExc.overflow) r.code = excOv;
        else begin
            r.excTaken = 1'b0;
            r.eret     = ins.upExc.eret;
        end
        r.flush = r.excTaken || r.eret;
        base    = mBev ? 32'hBFC0_0200 : 32'h8000_0000;
        if (r.eret) r.vector = mEpc;
        else if (r.excTaken && r.badV && !mis && !mExl) r.vector = base; // refill vector
        else r.vector = base + 32'h180;
        case (ins.wbSel)
            wbPcPlus8: r.result = ins.pc + 32'd8;
            wbCp0Data: r.result = cp0Read(ins.cp0Addr);
            default:   r.result = ins.aluOut;
        endcase
        r.dst      = ins.dst;
        r.regWrite = vld && ins.regWrite && !r.flush && !r.stall;
        r.reqValid = access && !r.flush && !r.stall;
        r.reqWrite = ins.isStore;
        r.byteEn   = ins.byteEn;
        r.wdata    = ins.storeData;
        return r;
    endfunction

    task automatic resetModel();
        {mBev, mExl, mIe, mBd, mBufValid} = 5'b10000;
        {mIm, mAsid, mIpSw} = '0;
        mCode = excInt;
        {mEpc, mBadV, mVpn2, mBuf} = '0;
    endtask

    // state change at the next rising edge
    task automatic commitModel(input exeToMemT ins, input logic vld, input expT r);
        if (r.stall) begin
            mBuf      = tlbGet(ins.aluOut[31:13]);
            mBufValid = 1'b1;
        end
        if (r.excTaken) begin
            mEpc  = ins.inDelaySlot ? ins.pc - 32'd4 : ins.pc;
            mBd   = ins.inDelaySlot;
            mCode = r.code;
            mExl  = 1'b1;
            if (r.badV) mBadV = ins.aluOut;
            if (r.code == excTlbL || r.code == excTlbS) mVpn2 = ins.aluOut[31:13];
        end else if (r.eret) begin
            mExl = 1'b0;
        end else if (vld && ins.isMtc0) begin
            case (ins.cp0Addr)
                cp0Status: {mBev, mIm, mExl, mIe} =
                    {ins.storeData[22], ins.storeData[15:8], ins.storeData[1:0]};
                cp0Cause: mIpSw = ins.storeData[9:8];
                cp0Epc:   mEpc = ins.storeData;
                cp0EntryHi: begin
                    {mVpn2, mAsid} = {ins.storeData[31:13], ins.storeData[7:0]};
                    mBufValid = 1'b0; // buffer dropped
                end
                default: ;
            endcase
        end
    endtask

    task automatic checkValue(input string name, input wordT got, input wordT want);
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
            ipHwRef   <= '0;
        end else begin
            ipHwRef <= interrupt;
            if (memFlush) heldValid <= 1'b0;
            else if (memWr) heldValid <= exeIn.valid;
        end
        if (arstN && memWr) heldIns <= exeIn;
    end

    // compare on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (!arstN) begin
            resetModel();
        end else begin
            exp = refModel(heldIns, heldValid);
            checkValue("tlbStall", 32'(tlbStall), 32'(exp.stall));
            checkValue("excFlush", 32'(excFlush), 32'(exp.flush));
            checkValue("wbOut.regWrite", 32'(wbOut.regWrite), 32'(exp.regWrite));
            checkValue("dmemReq.valid", 32'(dmemReq.valid), 32'(exp.reqValid));
            if (exp.lookup) checkValue("tlbVpn2", 32'(tlbVpn2), 32'(exp.vpn2));
            if (exp.flush) checkValue("excVector", excVector, exp.vector);
            if (exp.regWrite) begin
                checkValue("wbOut.dst", 32'(wbOut.dst), 32'(exp.dst));
                checkValue("wbOut.result", wbOut.result, exp.result);
            end
            if (exp.reqValid) begin
                checkValue("dmemReq.write", 32'(dmemReq.write), 32'(exp.reqWrite));
                checkValue("dmemReq.paddr", dmemReq.paddr, exp.paddr);
                checkValue("dmemReq.cached", 32'(dmemReq.cached), 32'(exp.cached));
                checkValue("dmemReq.byteEn", 32'(dmemReq.byteEn), 32'(exp.byteEn));
                if (exp.reqWrite) checkValue("dmemReq.wdata", dmemReq.wdata, exp.wdata);
            end
            commitModel(heldIns, heldValid, exp);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", maxCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic exeToMemT newIns(input wordT pc);
        exeToMemT i;
        i         = '0;
        i.valid   = 1'b1;
        i.pc      = pc;
        i.wbSel   = wbAluOut;
        i.memSize = sizeWord;
        return i;
    endfunction

    // starts at a falling edge and holds back while the stage stalls
    task automatic issue(input exeToMemT ins, input logic flush);
        while (tlbStall) begin
            memWr = 1'b0;
            @(negedge clk);
        end
        exeIn    = ins;
        memWr    = 1'b1;
        memFlush = flush;
        pcNext   = pcNext + 32'd4;
        @(negedge clk);
        memWr    = 1'b0;
        memFlush = 1'b0;
    endtask

    task automatic mtc0(input regAddrT a, input wordT d);
        exeToMemT i;
        i           = newIns(pcNext);
        i.isMtc0    = 1'b1;
        i.cp0Addr   = a;
        i.storeData = d;
        issue(i, 1'b0);
    endtask

    task automatic mfc0(input regAddrT a);
        exeToMemT i;
        i          = newIns(pcNext);
        i.isMfc0   = 1'b1;
        i.cp0Addr  = a;
        i.wbSel    = wbCp0Data;
        i.regWrite = 1'b1;
        i.dst      = 5'd3;
        issue(i, 1'b0);
    endtask

    task automatic memAccess(input wordT va, input logic st, input memSizeE sz, input byteEnT be);
        exeToMemT i;
        i           = newIns(pcNext);
        i.aluOut    = va;
        i.isLoad    = !st;
        i.isStore   = st;
        i.regWrite  = !st;
        i.dst       = 5'd9;
        i.memSize   = sz;
        i.byteEn    = be;
        i.storeData = $random(seed);
        issue(i, 1'b0);
    endtask

    task automatic runRandom(input int n, input logic mem);
        exeToMemT i;
        wordT     r;
        for (int k = 0; k < n; k++) begin
            r = $random(seed);
            if (mem) begin
                memAccess({2'b10, r[31], r[28:2], 2'b00}, r[0], memSizeE'(r[2:1] % 3), r[6:3]);
            end else begin
                i          = newIns(pcNext);
                i.aluOut   = $random(seed);
                i.wbSel    = r[0] ? wbPcPlus8 : wbAluOut;
                i.dst      = r[5:1];
                i.regWrite = r[6];
                issue(i, r[9:7] == 3'd0); // occasional flush
            end
        end
    endtask

    task automatic excCase(input int kind, input logic ds);
        exeToMemT i;
        i             = newIns(pcNext);
        i.inDelaySlot = ds;
        i.regWrite    = 1'b1;
        case (kind)
            0: begin
                i.isLoad = 1'b1;
                i.aluOut = 32'h8000_1002;
            end
            1: begin
                i.isStore = 1'b1;
                i.memSize = sizeHalf;
                i.aluOut  = 32'hA000_0101;
            end
            2: i.upExc.syscall = 1'b1;
            3: i.upExc.brk = 1'b1;
            4: i.upExc.reservedInstr = 1'b1;
            default: i.upExc.overflow = 1'b1;
        endcase
        issue(i, 1'b0);
        mfc0(cp0Epc);
        mfc0(cp0Cause);
        mtc0(cp0Status, 32'h0); // leave exception level
    endtask

    initial begin
        exeToMemT i;
        {clk, arstN, memWr, memFlush} = 4'b0000;
        exeIn     = '0;
        interrupt = '0;
        seed      = 60;
        errors    = 0;
        cycles    = 0;
        pcNext    = 32'hBFC0_0000;
        tlbTable[0] = {19'h00010, 20'h12345, 1'b1, 1'b1, 20'h54321, 1'b1, 1'b0};
        tlbTable[1] = {19'h00011, 20'h0AAAA, 1'b1, 1'b0, 20'h0BBBB, 1'b0, 1'b1}; // odd invalid
        tlbTable[2] = {19'h00012, 20'h00777, 1'b1, 1'b1, 20'h00778, 1'b1, 1'b1};
        tlbTable[3] = {19'h00013, 20'h00999, 1'b1, 1'b0, 20'h0099A, 1'b1, 1'b0};
        repeat (16) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        runRandom(120, 1'b0);
        runRandom(60, 1'b1);
        mtc0(cp0Status, 32'h0); // BEV off
        memAccess({19'h00010, 1'b0, 12'h010}, 1'b0, sizeWord, 4'hF); // miss then refill
        memAccess({19'h00010, 1'b1, 12'h124}, 1'b1, sizeWord, 4'h3); // hit
        memAccess({19'h00011, 1'b1, 12'h000}, 1'b0, sizeWord, 4'hF); // invalid half
        mtc0(cp0Status, 32'h0);
        memAccess({19'h00020, 1'b0, 12'h048}, 1'b0, sizeWord, 4'hF); // not in table
        mfc0(cp0BadVAddr);
        mtc0(cp0Status, 32'h0);
        for (int k = 0; k < 6; k++) excCase(k, k[0]);
        mtc0(cp0Status, 32'h0000_0401); // IM2 and IE
        interrupt = 6'b000001;
        i = newIns(pcNext);
        i.aluOut = 32'h1234_5678;
        i.regWrite = 1'b1;
        issue(i, 1'b0);
        interrupt = '0;
        mfc0(cp0Cause);
        i = newIns(pcNext);
        i.upExc.eret = 1'b1;
        issue(i, 1'b0);
        mfc0(cp0Status);
        mtc0(cp0EntryHi, 32'h0000_2000);
        memAccess({19'h00011, 1'b0, 12'h020}, 1'b0, sizeWord, 4'hF); // buffered page refills
        repeat (3) issue('0, 1'b0);
        $display("errors: %0d mismatches in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
verilog/memStagePkg.sv
verilog/memReg.sv
verilog/dataTlbBuffer.sv
verilog/cp0Regs.sv
verilog/exceptionUnit.sv
verilog/memStageTop.sv
verif/memStageTb.sv

//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module memStageTb -o memStageSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/memStageSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
